/* include/afe_dac_defaults.svh */
`ifndef AFE_DAC_DEFAULTS_SVH
`define AFE_DAC_DEFAULTS_SVH

// command nibble in [27:24], channel address in [23:20], code in [19:4]

`define DAC1_DEF_MODE   32'h0900_0001 // internal reference on
`define DAC1_DEF_LDAC   32'h0600_000F // all channels transparent
`define DAC1_DEF_DCEN   32'h0800_0001 // daisy chain on
`define DAC1_DEF_CHAN_A 32'h0308_0000 // mid scale
`define DAC1_DEF_CHAN_B 32'h0318_0000
`define DAC1_DEF_CHAN_C 32'h0328_0000
`define DAC1_DEF_CHAN_D 32'h0338_0000

`define DAC2_DEF_MODE   32'h0900_0001
`define DAC2_DEF_LDAC   32'h0600_000F
`define DAC2_DEF_DCEN   32'h0800_0001
`define DAC2_DEF_CHAN_A 32'h0304_0000 // quarter scale
`define DAC2_DEF_CHAN_B 32'h0314_0000
`define DAC2_DEF_CHAN_C 32'h0324_0000
`define DAC2_DEF_CHAN_D 32'h0334_0000

`define DAC3_DEF_MODE   32'h0900_0001
`define DAC3_DEF_LDAC   32'h0600_000F
`define DAC3_DEF_DCEN   32'h0800_0001
`define DAC3_DEF_CHAN_A 32'h030C_0000 // three quarter scale
`define DAC3_DEF_CHAN_B 32'h031C_0000
`define DAC3_DEF_CHAN_C 32'h032C_0000
`define DAC3_DEF_CHAN_D 32'h033C_0000

`endif

/* rtl/afe_dac_pkg.sv */
package afe_dac_pkg;

`include "afe_dac_defaults.svh"

    // ========================================
    // sizes
    // ========================================
    localparam int N_CHIPS    = 3;            // chips in the daisy chain
    localparam int N_FIELDS   = 7;            // registers per chip
    localparam int N_STEPS    = 12;           // frames per configuration
    localparam int WORD_W     = 32;           // one chip command word
    localparam int ADDR_W     = 5;
    localparam int CHIP_W     = 2;
    localparam int FLD_W      = 3;
    localparam int STEP_W     = 4;
    localparam int CNT_W      = 2;            // words per frame, 1 to 3
    localparam int BIT_CNT_W  = 7;            // up to 96 bits per frame
    localparam int FRAME_BITS = N_CHIPS * WORD_W;

    localparam logic [ADDR_W-1:0] CTRL_ADDR = 5'd26;

    // field codes, also the field's slot in the address map
    localparam logic [FLD_W-1:0] FLD_MODE   = 3'd0;
    localparam logic [FLD_W-1:0] FLD_LDAC   = 3'd1;
    localparam logic [FLD_W-1:0] FLD_DCEN   = 3'd2;
    localparam logic [FLD_W-1:0] FLD_CHAN_A = 3'd3;
    localparam logic [FLD_W-1:0] FLD_CHAN_B = 3'd4;
    localparam logic [FLD_W-1:0] FLD_CHAN_C = 3'd5;
    localparam logic [FLD_W-1:0] FLD_CHAN_D = 3'd6;

    // ========================================
    // types
    // ========================================
    typedef logic [WORD_W-1:0] dac_word_t;

    typedef struct packed {
        dac_word_t mode;
        dac_word_t ldac;
        dac_word_t dcen;
        dac_word_t chan_a;
        dac_word_t chan_b;
        dac_word_t chan_c;
        dac_word_t chan_d;
    } chip_regs_t;

    typedef struct packed {
        logic              sel;
        logic              sync;
        logic              wr_en;
        logic [ADDR_W-1:0] addr;
        dac_word_t         data;
    } bus_wr_t;

    typedef struct packed {
        logic              valid;
        logic [CHIP_W-1:0] chip;
        logic [FLD_W-1:0]  field;
        dac_word_t         data;
    } reg_wr_t;

    typedef struct packed {
        logic [CNT_W-1:0]          nwords;
        dac_word_t [N_CHIPS-1:0]   words;  // words[i] goes to chip i
    } frame_t;

    // ========================================
    // configuration sequence
    // ========================================
    // ldac/dcen repeated so the chain is opened one chip at a time
    localparam logic [FLD_W-1:0] FRAME_ORDER [N_STEPS] = '{
        FLD_LDAC, FLD_DCEN, FLD_LDAC, FLD_DCEN, FLD_LDAC, FLD_DCEN,
        FLD_MODE, FLD_CHAN_A, FLD_CHAN_B, FLD_CHAN_C, FLD_CHAN_D, FLD_MODE
    };

    localparam logic [CNT_W-1:0] FRAME_WORDS [N_STEPS] = '{
        2'd1, 2'd1, 2'd2, 2'd2, 2'd3, 2'd3,
        2'd3, 2'd3, 2'd3, 2'd3, 2'd3, 2'd3
    };

    // [chip][field]
    localparam dac_word_t DEF_WORD [N_CHIPS][N_FIELDS] = '{
        '{`DAC1_DEF_MODE, `DAC1_DEF_LDAC, `DAC1_DEF_DCEN, `DAC1_DEF_CHAN_A,
          `DAC1_DEF_CHAN_B, `DAC1_DEF_CHAN_C, `DAC1_DEF_CHAN_D},
        '{`DAC2_DEF_MODE, `DAC2_DEF_LDAC, `DAC2_DEF_DCEN, `DAC2_DEF_CHAN_A,
          `DAC2_DEF_CHAN_B, `DAC2_DEF_CHAN_C, `DAC2_DEF_CHAN_D},
        '{`DAC3_DEF_MODE, `DAC3_DEF_LDAC, `DAC3_DEF_DCEN, `DAC3_DEF_CHAN_A,
          `DAC3_DEF_CHAN_B, `DAC3_DEF_CHAN_C, `DAC3_DEF_CHAN_D}
    };

    localparam dac_word_t CTRL_DEFAULT = 32'h0000_0001;

endpackage

/* rtl/afe_dac_bus_decode.sv */
`timescale 1ns/1ps

module afe_dac_bus_decode (
    input  logic                 clk10,
    input  logic                 resetS,
    input  afe_dac_pkg::bus_wr_t bus,
    output afe_dac_pkg::reg_wr_t reg_wr,
    output logic                 cfg_trigger_level
);
    import afe_dac_pkg::*;

    logic              wr_hit;
    logic              data_hit;
    logic              ctrl_hit;
    logic              wr_valid;
    logic [CHIP_W-1:0] wr_chip;
    logic [FLD_W-1:0]  wr_field;
    dac_word_t         wr_data;

    assign wr_hit   = bus.sel & bus.sync & bus.wr_en;
    assign data_hit = wr_hit && (bus.addr < ADDR_W'(N_CHIPS * N_FIELDS)); // 0..20 only
    assign ctrl_hit = wr_hit && (bus.addr == CTRL_ADDR);

    always_ff @(posedge clk10) begin
        if (resetS) begin
            wr_valid          <= 1'b0;
            cfg_trigger_level <= CTRL_DEFAULT[0]; // brings up the default sequence
        end else begin
            wr_valid <= data_hit;
            if (ctrl_hit) begin
                cfg_trigger_level <= bus.data[0]; // only bit 0 is stored
            end
        end
    end

    // address = 3 * field + chip
    always_ff @(posedge clk10) begin
        if (data_hit) begin
            wr_chip  <= CHIP_W'(bus.addr % ADDR_W'(N_CHIPS));
            wr_field <= FLD_W'(bus.addr / ADDR_W'(N_CHIPS));
            wr_data  <= bus.data;
        end
    end

    assign reg_wr = '{valid: wr_valid, chip: wr_chip, field: wr_field, data: wr_data};

endmodule

/* rtl/afe_dac_chip_regs.sv */
`timescale 1ns/1ps

module afe_dac_chip_regs #(
    parameter int CHIP = 0
) (
    input  logic                    clk10,
    input  logic                    resetS,
    input  afe_dac_pkg::reg_wr_t    reg_wr,
    output afe_dac_pkg::chip_regs_t regs
);
    import afe_dac_pkg::*;

    logic my_write;

    assign my_write = reg_wr.valid && (reg_wr.chip == CHIP_W'(CHIP));

    always_ff @(posedge clk10) begin
        if (resetS) begin
            // power-up values for this chip
            regs.mode   <= DEF_WORD[CHIP][FLD_MODE];
            regs.ldac   <= DEF_WORD[CHIP][FLD_LDAC];
            regs.dcen   <= DEF_WORD[CHIP][FLD_DCEN];
            regs.chan_a <= DEF_WORD[CHIP][FLD_CHAN_A];
            regs.chan_b <= DEF_WORD[CHIP][FLD_CHAN_B];
            regs.chan_c <= DEF_WORD[CHIP][FLD_CHAN_C];
            regs.chan_d <= DEF_WORD[CHIP][FLD_CHAN_D];
        end else if (my_write) begin
            case (reg_wr.field)
                FLD_MODE:   regs.mode   <= reg_wr.data;
                FLD_LDAC:   regs.ldac   <= reg_wr.data;
                FLD_DCEN:   regs.dcen   <= reg_wr.data;
                FLD_CHAN_A: regs.chan_a <= reg_wr.data;
                FLD_CHAN_B: regs.chan_b <= reg_wr.data;
                FLD_CHAN_C: regs.chan_c <= reg_wr.data;
                FLD_CHAN_D: regs.chan_d <= reg_wr.data;
                default: begin
                    // code 7 never decoded
                end
            endcase
        end
    end

endmodule

/* rtl/afe_dac_frame_seq.sv */
`timescale 1ns/1ps

module afe_dac_frame_seq (
    input  logic                    clk10,
    input  logic                    resetS,
    input  logic                    cfg_trigger_level,
    input  afe_dac_pkg::chip_regs_t chip_regs [afe_dac_pkg::N_CHIPS],
    input  logic                    shift_busy,
    output logic                    frame_start,
    output afe_dac_pkg::frame_t     frame,
    output logic                    config_busy
);
    import afe_dac_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,      // waiting for a free shifter
        S_WAIT_HI,  // frame handed over, wait for busy
        S_WAIT_LO   // frame on the wire
    } state_t;

    state_t            state;
    logic [STEP_W-1:0] step;
    logic              trig_d;
    logic              trig_rise;
    logic              issue;
    frame_t            next_frame;

    function automatic dac_word_t pick_field(chip_regs_t r, logic [FLD_W-1:0] f);
        dac_word_t w;
        case (f)
            FLD_MODE:   w = r.mode;
            FLD_LDAC:   w = r.ldac;
            FLD_DCEN:   w = r.dcen;
            FLD_CHAN_A: w = r.chan_a;
            FLD_CHAN_B: w = r.chan_b;
            FLD_CHAN_C: w = r.chan_c;
            FLD_CHAN_D: w = r.chan_d;
            default:    w = '0;
        endcase
        return w;
    endfunction

    assign trig_rise = cfg_trigger_level & ~trig_d;
    assign issue     = (state == S_RUN) && !shift_busy;

    // same field from every chip, word i for chip i
    always_comb begin
        next_frame.nwords = FRAME_WORDS[step];
        for (int c = 0; c < N_CHIPS; c++) begin
            next_frame.words[c] = pick_field(chip_regs[c], FRAME_ORDER[step]);
        end
    end

    // ========================================
    // sequence control
    // ========================================
    always_ff @(posedge clk10) begin
        if (resetS) begin
            state       <= S_IDLE;
            step        <= '0;
            trig_d      <= 1'b0; // level of 1 after reset counts as an edge
            frame_start <= 1'b0;
            config_busy <= 1'b0;
        end else begin
            trig_d      <= cfg_trigger_level;
            frame_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (trig_rise) begin
                        step        <= '0;
                        config_busy <= 1'b1;
                        state       <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (issue) begin
                        frame_start <= 1'b1;
                        state       <= S_WAIT_HI;
                    end
                end
                S_WAIT_HI: begin
                    if (shift_busy) begin
                        state <= S_WAIT_LO;
                    end
                end
                S_WAIT_LO: begin
                    if (!shift_busy) begin
                        if (step == STEP_W'(N_STEPS - 1)) begin
                            config_busy <= 1'b0;
                            state       <= S_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= S_RUN;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk10) begin
        if (issue) begin
            frame <= next_frame; // held stable for the shifter capture
        end
    end

endmodule

/* rtl/afe_dac_shifter.sv */
`timescale 1ns/1ps

module afe_dac_shifter (
    input  logic                clk10,
    input  logic                resetS,
    input  logic                frame_start,
    input  afe_dac_pkg::frame_t frame,
    output logic                shift_busy,
    output logic                sdi,
    output logic                sync_n
);
    import afe_dac_pkg::*;

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_LOAD,   // frame captured, sync_n falls next
        SH_SHIFT,
        SH_DONE    // sync_n back high for one cycle
    } sh_state_t;

    sh_state_t              state;
    logic [BIT_CNT_W-1:0]   bits_left;
    logic [FRAME_BITS-1:0]  sreg;
    logic [FRAME_BITS-1:0]  load_bits;
    logic                   capture;

    assign capture = (state == SH_IDLE) && frame_start;

    // left align so the highest used word leaves first
    always_comb begin
        case (frame.nwords)
            2'd1:    load_bits = {frame.words[0], {(2 * WORD_W){1'b0}}};
            2'd2:    load_bits = {frame.words[1], frame.words[0], {WORD_W{1'b0}}};
            default: load_bits = frame.words;
        endcase
    end

    always_ff @(posedge clk10) begin
        if (resetS) begin
            state      <= SH_IDLE;
            bits_left  <= '0;
            shift_busy <= 1'b0;
            sync_n     <= 1'b1;
        end else begin
            case (state)
                SH_IDLE: begin
                    if (frame_start) begin
                        bits_left  <= BIT_CNT_W'(frame.nwords) * BIT_CNT_W'(WORD_W);
                        shift_busy <= 1'b1;
                        state      <= SH_LOAD;
                    end
                end
                SH_LOAD: begin
                    sync_n <= 1'b0;
                    state  <= SH_SHIFT;
                end
                SH_SHIFT: begin
                    bits_left <= bits_left - 1'b1;
                    if (bits_left == BIT_CNT_W'(1)) begin
                        sync_n <= 1'b1; // exactly 32*k cycles low
                        state  <= SH_DONE;
                    end
                end
                SH_DONE: begin
                    shift_busy <= 1'b0;
                    state      <= SH_IDLE;
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk10) begin
        if (capture) begin
            sreg <= load_bits;
        end else if (state == SH_SHIFT) begin
            sreg <= {sreg[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign sdi = sreg[FRAME_BITS-1]; // changes on rising edge, dac samples on falling

endmodule

/* rtl/afe_dac_intf.sv */
`timescale 1ns/1ps

module afe_dac_intf (
    input  logic                           clk10,
    input  logic                           resetS,
    input  logic                           io_sel,
    input  logic                           io_sync,
    input  logic                           io_wr_en,
    input  logic [afe_dac_pkg::ADDR_W-1:0] io_addr,
    input  afe_dac_pkg::dac_word_t         io_wr_data,
    output logic                           sclk,
    output logic                           sdi,
    output logic                           sync_n,
    output logic                           config_busy
);
    import afe_dac_pkg::*;

    bus_wr_t    bus;
    reg_wr_t    reg_wr;
    logic       cfg_trigger_level;
    chip_regs_t chip_regs [N_CHIPS];
    logic       frame_start;
    frame_t     frame;
    logic       shift_busy;

    assign sclk = clk10; // serial clock runs continuously

    assign bus = '{sel: io_sel, sync: io_sync, wr_en: io_wr_en,
                   addr: io_addr, data: io_wr_data};

    afe_dac_bus_decode i_bus_decode (
        .clk10             (clk10),
        .resetS            (resetS),
        .bus               (bus),
        .reg_wr            (reg_wr),
        .cfg_trigger_level (cfg_trigger_level)
    );

    // ========================================
    // one register bank per chip
    // ========================================
    for (genvar c = 0; c < N_CHIPS; c++) begin : g_chip
        afe_dac_chip_regs #(
            .CHIP (c)
        ) i_chip_regs (
            .clk10  (clk10),
            .resetS (resetS),
            .reg_wr (reg_wr),
            .regs   (chip_regs[c])
        );
    end

    afe_dac_frame_seq i_frame_seq (
        .clk10             (clk10),
        .resetS            (resetS),
        .cfg_trigger_level (cfg_trigger_level),
        .chip_regs         (chip_regs),
        .shift_busy        (shift_busy),
        .frame_start       (frame_start),
        .frame             (frame),
        .config_busy       (config_busy)
    );

    afe_dac_shifter i_shifter (
        .clk10       (clk10),
        .resetS      (resetS),
        .frame_start (frame_start),
        .frame       (frame),
        .shift_busy  (shift_busy),
        .sdi         (sdi),
        .sync_n      (sync_n)
    );

endmodule

/* verif/afe_dac_assert.sv */
`timescale 1ns/1ps

module afe_dac_assert (
    input logic clk10,
    input logic resetS,
    input logic sync_n,
    input logic config_busy
);
    int         assert_fails = 0; // read by the testbench at the end of the run
    logic [7:0] low_len;

    // length of the current sync_n low run
    always @(posedge clk10) begin
        if (resetS || sync_n) begin
            low_len <= '0;
        end else begin
            low_len <= low_len + 1'b1;
        end
    end

    a_sync_in_run: assert property (@(posedge clk10) disable iff (resetS)
        !sync_n |-> config_busy)
        else begin
            assert_fails++;
            $error("sync_n low while no configuration runs");
        end

    a_frame_len: assert property (@(posedge clk10) disable iff (resetS)
        $rose(sync_n) |-> (low_len == 8'd32 || low_len == 8'd64 || low_len == 8'd96))
        else begin
            assert_fails++;
            $error("sync_n low run of %0d cycles", $sampled(low_len));
        end

    a_reset_idle: assert property (@(posedge clk10) resetS |=> sync_n)
        else begin
            assert_fails++;
            $error("sync_n low while reset is held");
        end

endmodule

bind afe_dac_intf afe_dac_assert i_afe_dac_assert (
    .clk10       (clk10),
    .resetS      (resetS),
    .sync_n      (sync_n),
    .config_busy (config_busy)
);

/* verif/tb_afe_dac.sv */
`timescale 1ns/1ps

module tb_afe_dac;
    import afe_dac_pkg::*;

    // five sequences of about 1100 cycles, 300 idle cycles, ~200 writes of 2 cycles
    localparam int MAX_CYCLES = 20000;

    logic                  clk10;
    logic                  resetS;
    logic                  io_sel;
    logic                  io_sync;
    logic                  io_wr_en;
    logic [ADDR_W-1:0]     io_addr;
    dac_word_t             io_wr_data;
    logic                  sclk;
    logic                  sdi;
    logic                  sync_n;
    logic                  config_busy;

    dac_word_t             model [N_CHIPS][N_FIELDS]; // expected register contents
    integer                seed;
    int                    cycles = 0;
    int                    sclk_edges = 0;
    int                    frame_count = 0;           // frames since the last reset
    int                    bit_count = 0;
    logic [FRAME_BITS-1:0] cap_bits = '0;
    logic                  in_frame = 1'b0;

    afe_dac_intf i_afe_dac_intf (
        .clk10       (clk10),
        .resetS      (resetS),
        .io_sel      (io_sel),
        .io_sync     (io_sync),
        .io_wr_en    (io_wr_en),
        .io_addr     (io_addr),
        .io_wr_data  (io_wr_data),
        .sclk        (sclk),
        .sdi         (sdi),
        .sync_n      (sync_n),
        .config_busy (config_busy)
    );

    initial begin
        clk10 = 1'b0;
        forever #4 clk10 = ~clk10;
    end

    always @(posedge clk10) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "run limit reached");
        end
    end

    task automatic check_value(input string what, input logic [FRAME_BITS-1:0] got,
                               input logic [FRAME_BITS-1:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // sclk is clk10 passed straight through
    always @(posedge sclk) begin
        sclk_edges++;
        check_value("clk10 level at sclk rise", clk10, 1'b1);
    end

    task automatic load_defaults();
        for (int c = 0; c < N_CHIPS; c++) begin
            for (int f = 0; f < N_FIELDS; f++) begin
                model[c][f] = DEF_WORD[c][f];
            end
        end
    endtask

    // highest chip first, right aligned like the capture register
    function automatic logic [FRAME_BITS-1:0] expected_frame(input int step);
        logic [FRAME_BITS-1:0] bits;
        bits = '0;
        for (int w = int'(FRAME_WORDS[step]) - 1; w >= 0; w--) begin
            bits = {bits[FRAME_BITS-WORD_W-1:0], model[w][FRAME_ORDER[step]]};
        end
        return bits;
    endfunction

    // ========================================
    // serial capture on the falling edge
    // ========================================
    always @(negedge clk10) begin : capture
        int step;
        step = frame_count % N_STEPS;
        if (resetS) begin
            in_frame    = 1'b0; // partial frame is dropped
            bit_count   = 0;
            frame_count = 0;
            cap_bits    = '0;
        end else if (!sync_n) begin
            in_frame  = 1'b1;
            cap_bits  = {cap_bits[FRAME_BITS-2:0], sdi};
            bit_count = bit_count + 1;
        end else if (in_frame) begin
            check_value($sformatf("frame %0d length", step), bit_count,
                        WORD_W * FRAME_WORDS[step]);
            check_value($sformatf("frame %0d content", step), cap_bits, expected_frame(step));
            in_frame    = 1'b0;
            bit_count   = 0;
            cap_bits    = '0;
            frame_count = frame_count + 1;
        end
    end

    task automatic bus_write(input logic sel, input logic sync, input logic wr_en,
                             input logic [ADDR_W-1:0] addr, input dac_word_t data);
        @(posedge clk10);
        io_sel     <= sel;
        io_sync    <= sync;
        io_wr_en   <= wr_en;
        io_addr    <= addr;
        io_wr_data <= data;
        // field f of chip c sits at address 3*f + c
        for (int f = 0; f < N_FIELDS; f++) begin
            for (int c = 0; c < N_CHIPS; c++) begin
                if (sel && sync && wr_en && addr == N_CHIPS * f + c) begin
                    model[c][f] = data;
                end
            end
        end
        @(posedge clk10);
        io_sel   <= 1'b0;
        io_sync  <= 1'b0;
        io_wr_en <= 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        while (config_busy !== level) @(posedge clk10);
    endtask

    task automatic expect_sequence(input string name, input int base);
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_value({name, ": frames in sequence"}, frame_count - base, N_STEPS);
    endtask

    initial begin : main
        logic [31:0] r;
        int          base;
        seed       = 48461;
        resetS     = 1'b1;
        io_sel     = 1'b0;
        io_sync    = 1'b0;
        io_wr_en   = 1'b0;
        io_addr    = '0;
        io_wr_data = '0;
        load_defaults();
        repeat (5) @(posedge clk10);
        resetS <= 1'b0;
        expect_sequence("defaults after reset", 0);

        // random data on every mapped address
        for (int a = 0; a < N_CHIPS * N_FIELDS; a++) begin
            bus_write(1'b1, 1'b1, 1'b1, ADDR_W'(a), $random(seed));
        end
        base = frame_count;
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd0);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        expect_sequence("random writes", base);

        // ========================================
        // writes that must not land
        // ========================================
        for (int a = 0; a < N_CHIPS * N_FIELDS; a++) begin
            bus_write(a % 3 != 0, a % 3 != 1, a % 3 != 2, ADDR_W'(a), $random(seed));
        end
        for (int a = N_CHIPS * N_FIELDS; a < 32; a++) begin
            if (a != CTRL_ADDR) begin
                bus_write(1'b1, 1'b1, 1'b1, ADDR_W'(a), $random(seed));
            end
        end
        repeat (40) begin
            r = $random(seed);
            // control address only with wr_en low
            bus_write(r[5], r[6], r[7] && (r[4:0] != CTRL_ADDR), r[4:0], $random(seed));
        end
        base = frame_count;
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd0);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        expect_sequence("ignored writes", base);

        // level already 1, no edge
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        repeat (300) begin
            @(posedge clk10);
            check_value("sync_n after repeated trigger", sync_n, 1'b1);
            check_value("config_busy after repeated trigger", config_busy, 1'b0);
        end

        // retrigger in the middle of a run
        base = frame_count;
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd0);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        wait_busy(1'b1);
        while (frame_count - base < 3) @(posedge clk10);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd0);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        expect_sequence("trigger during run", base);
        repeat (50) @(posedge clk10);
        check_value("config_busy after ignored trigger", config_busy, 1'b0);

        // reset in the middle of a 96-bit frame
        base = frame_count;
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd0);
        bus_write(1'b1, 1'b1, 1'b1, CTRL_ADDR, 32'd1);
        while (frame_count - base < 5) @(posedge clk10);
        while (sync_n !== 1'b0) @(posedge clk10);
        repeat (20) @(posedge clk10);
        resetS <= 1'b1;
        load_defaults();
        repeat (5) @(posedge clk10);
        check_value("sync_n during reset", sync_n, 1'b1);
        check_value("config_busy during reset", config_busy, 1'b0);
        resetS <= 1'b0;
        expect_sequence("defaults after mid-frame reset", 0);

        repeat (10) @(posedge clk10);
        @(negedge clk10);
        check_value("sclk rising edges against clk10 cycles", sclk_edges, cycles);
        if (i_afe_dac_intf.i_afe_dac_assert.assert_fails == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d serial protocol assertion failures",
                     i_afe_dac_intf.i_afe_dac_assert.assert_fails);
            $display("TESTS FAILED");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

/* compile.f */
+incdir+include
rtl/afe_dac_pkg.sv
rtl/afe_dac_bus_decode.sv
rtl/afe_dac_chip_regs.sv
rtl/afe_dac_frame_seq.sv
rtl/afe_dac_shifter.sv
rtl/afe_dac_intf.sv
verif/afe_dac_assert.sv
verif/tb_afe_dac.sv
